// File: filelist.f
logic/rv_int_pkg.sv
logic/pipe_stage.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/alu.sv
logic/exec_unit.sv
logic/rv_int_core.sv
sim/rv_int_core_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_int_pkg::data_t a_i,
    input  rv_int_pkg::data_t b_i,
    input  logic [2:0]        funct3_i,
    input  logic              mod_i,
    input  logic              word_i,
    input  logic              use_imm_i,
    output rv_int_pkg::data_t result_o
);

    logic              sub;
    logic [5:0]        shamt;
    logic [4:0]        shamt_w;
    logic [31:0]       a_w;
    logic [31:0]       b_w;
    rv_int_pkg::data_t sra_d;
    logic [31:0]       sra_w;
    rv_int_pkg::data_t res_d;
    logic [31:0]       res_w;

    // immediate forms carry imm[10] in the mod bit, so no subtract there
    assign sub     = mod_i && !use_imm_i;
    assign shamt   = b_i[5:0];
    assign shamt_w = b_i[4:0];
    assign a_w     = a_i[31:0];
    assign b_w     = b_i[31:0];
    assign sra_d   = $signed(a_i) >>> shamt;
    assign sra_w   = $signed(a_w) >>> shamt_w;

    always_comb begin
        case (funct3_i)
            rv_int_pkg::f3_add: begin
                res_d = sub ? (a_i - b_i) : (a_i + b_i);
                res_w = sub ? (a_w - b_w) : (a_w + b_w);
            end
            rv_int_pkg::f3_sll: begin
                res_d = a_i << shamt;
                res_w = a_w << shamt_w;
            end
            rv_int_pkg::f3_slt: begin
                res_d = {{(rv_int_pkg::xlen-1){1'b0}}, $signed(a_i) < $signed(b_i)};
                res_w = {31'b0, $signed(a_w) < $signed(b_w)};
            end
            rv_int_pkg::f3_sltu: begin
                res_d = {{(rv_int_pkg::xlen-1){1'b0}}, a_i < b_i};
                res_w = {31'b0, a_w < b_w};
            end
            rv_int_pkg::f3_xor: begin
                res_d = a_i ^ b_i;
                res_w = a_w ^ b_w;
            end
            rv_int_pkg::f3_sr: begin
                res_d = mod_i ? sra_d : (a_i >> shamt);
                res_w = mod_i ? sra_w : (a_w >> shamt_w);
            end
            rv_int_pkg::f3_or: begin
                res_d = a_i | b_i;
                res_w = a_w | b_w;
            end
            default: begin
                res_d = a_i & b_i;
                res_w = a_w & b_w;
            end
        endcase
    end

    // word ops sign-extend bit 31
    assign result_o = word_i ? {{32{res_w[31]}}, res_w} : res_d;

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  rv_int_pkg::dec_t  dec_i,
    input  rv_int_pkg::data_t rs1_data_i,
    input  rv_int_pkg::data_t rs2_data_i,
    input  logic              fw_valid_i,
    input  rv_int_pkg::wb_t   fw_i,
    output rv_int_pkg::wb_t   res_o
);

    logic              fw_rs1;
    logic              fw_rs2;
    rv_int_pkg::data_t rs1_val;
    rv_int_pkg::data_t rs2_val;
    rv_int_pkg::data_t op_a;
    rv_int_pkg::data_t op_b;
    rv_int_pkg::data_t alu_res;

    // retire stage holds the only result not yet in the regfile
    assign fw_rs1 = fw_valid_i && (fw_i.rd != '0) && (fw_i.rd == dec_i.rs1);
    assign fw_rs2 = fw_valid_i && (fw_i.rd != '0) && (fw_i.rd == dec_i.rs2);

    assign rs1_val = fw_rs1 ? fw_i.data : rs1_data_i;
    assign rs2_val = fw_rs2 ? fw_i.data : rs2_data_i;

    // lui adds its immediate to zero
    assign op_a = dec_i.lui ? '0 : rs1_val;
    assign op_b = dec_i.use_imm ? dec_i.imm : rs2_val;

    alu u_alu (
        .a_i       (op_a),
        .b_i       (op_b),
        .funct3_i  (dec_i.funct3),
        .mod_i     (dec_i.mod),
        .word_i    (dec_i.word),
        .use_imm_i (dec_i.use_imm),
        .result_o  (alu_res)
    );

    assign res_o.rd   = dec_i.rd;
    assign res_o.data = alu_res;

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  rv_int_pkg::inst_t instr_i,
    output rv_int_pkg::dec_t  dec_o,
    output logic              legal_o
);

    logic [6:0]        opcode;
    logic              is_imm;
    logic              is_rr;
    logic              is_lui;
    logic              is_word;
    rv_int_pkg::data_t imm_i_fmt;
    rv_int_pkg::data_t imm_u_fmt;

    assign opcode = instr_i[6:0];

    assign is_imm  = (opcode == rv_int_pkg::op_alri) || (opcode == rv_int_pkg::op_alriw);
    assign is_rr   = (opcode == rv_int_pkg::op_alrr) || (opcode == rv_int_pkg::op_alrrw);
    assign is_lui  = (opcode == rv_int_pkg::op_lui);
    assign is_word = (opcode == rv_int_pkg::op_alriw) || (opcode == rv_int_pkg::op_alrrw);

    assign legal_o = is_imm || is_rr || is_lui;

    // I-type
    assign imm_i_fmt = {{52{instr_i[31]}}, instr_i[31:20]};
    // U-type
    assign imm_u_fmt = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};

    always_comb begin
        dec_o.rd      = instr_i[11:7];
        dec_o.word    = is_word;
        dec_o.lui     = is_lui;
        dec_o.use_imm = !is_rr;

        // rs2 field is immediate bits outside of register-register forms
        if (is_rr) begin
            dec_o.rs2 = instr_i[24:20];
        end else begin
            dec_o.rs2 = '0;
        end

        // lui is add of the immediate to x0
        if (is_lui) begin
            dec_o.rs1    = '0;
            dec_o.imm    = imm_u_fmt;
            dec_o.funct3 = rv_int_pkg::f3_add;
            dec_o.mod    = 1'b0;
        end else begin
            dec_o.rs1    = instr_i[19:15];
            dec_o.imm    = imm_i_fmt;
            dec_o.funct3 = instr_i[14:12];
            dec_o.mod    = instr_i[30];
        end
    end

endmodule

// File: logic/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     c_clk,
    input  logic     c_rst_n,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     full;
    logic     load;
    payload_t hold;

    // room when empty or when the held entry leaves this cycle
    assign ready_o = !full || ready_i;
    assign load    = valid_i && ready_o;

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            full <= 1'b0;
        end else if (ready_o) begin
            full <= valid_i;
        end
    end

    always_ff @(posedge c_clk) begin
        if (load) begin
            hold <= data_i;
        end
    end

    assign valid_o = full;
    assign data_o  = hold;

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  rv_int_pkg::reg_addr_t rs1_i,
    input  rv_int_pkg::reg_addr_t rs2_i,
    output rv_int_pkg::data_t     rs1_data_o,
    output rv_int_pkg::data_t     rs2_data_o,
    input  logic                  we_i,
    input  rv_int_pkg::reg_addr_t rd_i,
    input  rv_int_pkg::data_t     rd_data_i
);

    rv_int_pkg::data_t regs [0:31];

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: logic/rv_int_core.sv
`timescale 1ns/1ps

module rv_int_core (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  rv_int_pkg::inst_t     in_instr_i,
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output rv_int_pkg::reg_addr_t wb_rd_o,
    output rv_int_pkg::data_t     wb_data_o
);

    rv_int_pkg::dec_t  dec;
    logic              legal;
    logic              dec_valid;
    logic              ex_valid;
    logic              ex_ready;
    rv_int_pkg::dec_t  ex_dec;
    rv_int_pkg::data_t rs1_data;
    rv_int_pkg::data_t rs2_data;
    rv_int_pkg::wb_t   ex_res;
    rv_int_pkg::wb_t   wb;
    logic              retire;

    inst_decoder u_dec (
        .instr_i (in_instr_i),
        .dec_o   (dec),
        .legal_o (legal)
    );

    // illegal instructions are acknowledged but never enter stage 1
    assign dec_valid = in_valid_i && legal;

    pipe_stage #(.payload_t(rv_int_pkg::dec_t)) u_stage1 (
        .c_clk   (c_clk),
        .c_rst_n (c_rst_n),
        .valid_i (dec_valid),
        .ready_o (in_ready_o),
        .data_i  (dec),
        .valid_o (ex_valid),
        .ready_i (ex_ready),
        .data_o  (ex_dec)
    );

    regfile u_rf (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .rs1_i      (ex_dec.rs1),
        .rs2_i      (ex_dec.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (retire),
        .rd_i       (wb.rd),
        .rd_data_i  (wb.data)
    );

    exec_unit u_ex (
        .dec_i      (ex_dec),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .fw_valid_i (wb_valid_o),
        .fw_i       (wb),
        .res_o      (ex_res)
    );

    pipe_stage #(.payload_t(rv_int_pkg::wb_t)) u_stage2 (
        .c_clk   (c_clk),
        .c_rst_n (c_rst_n),
        .valid_i (ex_valid),
        .ready_o (ex_ready),
        .data_i  (ex_res),
        .valid_o (wb_valid_o),
        .ready_i (wb_ready_i),
        .data_o  (wb)
    );

    assign retire    = wb_valid_o && wb_ready_i;
    assign wb_rd_o   = wb.rd;
    assign wb_data_o = wb.data;

endmodule

// File: logic/rv_int_pkg.sv
package rv_int_pkg;

    localparam int xlen = 64;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] data_t;
    typedef logic [31:0]     inst_t;

    // major opcodes of the kept classes
    localparam logic [6:0] op_alri  = 7'b0010011;
    localparam logic [6:0] op_alrr  = 7'b0110011;
    localparam logic [6:0] op_alriw = 7'b0011011;
    localparam logic [6:0] op_alrrw = 7'b0111011;
    localparam logic [6:0] op_lui   = 7'b0110111;

    // alu funct3
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // decode to execute
    typedef struct packed {
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        data_t      imm;
        logic [2:0] funct3;
        logic       mod;
        logic       use_imm;
        logic       word;
        logic       lui;
    } dec_t;

    // execute to retire
    typedef struct packed {
        reg_addr_t rd;
        data_t     data;
    } wb_t;

endpackage

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator, then search the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module rv_int_core_tb \
    -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vrv_int_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: sim/rv_int_core_tb.sv
`timescale 1ns/1ps

module rv_int_core_tb;

    // instructions over all tests, sizes the watchdog
    localparam int n_instr = 521;

    logic        c_clk;
    logic        c_rst_n;
    logic        in_valid_i;
    logic        in_ready_o;
    logic [31:0] in_instr_i;
    logic        wb_valid_o;
    logic        wb_ready_i;
    logic [4:0]  wb_rd_o;
    logic [63:0] wb_data_o;

    logic [31:0] lfsr;
    logic        throttle;
    logic [63:0] model [0:31] = '{default: '0};
    logic [68:0] exp_q [$];
    logic        hold = 1'b0;
    logic [4:0]  hold_rd;
    logic [63:0] hold_data;
    int          checks = 0;
    int          errors = 0;
    int          seen_checks = 0;
    int          seen_errors = 0;

    rv_int_core UUT (.*);

    initial begin
        c_clk = 1'b0;
        forever #4 c_clk = ~c_clk;
    end

    initial begin
        repeat (n_instr * 20 + 16) @(posedge c_clk);
        $display("timeout: the core stopped retiring instructions");
        $display("TEST FAIL");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // kind: 0 alri, 1 alrr, 2 alriw, 3 alrrw, 4 lui
    function automatic logic [31:0] rand_instr(input logic [2:0] kind);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        logic        w;
        logic [6:0]  op;
        f3  = 3'(rand_bits(3));
        rd  = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        imm = 12'(rand_bits(12));
        w   = kind[1];
        if (w && f3 != rv_int_pkg::f3_sll && f3 != rv_int_pkg::f3_sr) begin
            f3 = rv_int_pkg::f3_add;
        end
        // funct7 shape, bit 30 only for sub and sra
        if (kind[0] || f3 == rv_int_pkg::f3_sll || f3 == rv_int_pkg::f3_sr) begin
            imm = {1'b0, imm[10] && (f3 == rv_int_pkg::f3_sr || (f3 == rv_int_pkg::f3_add
                   && kind[0])), 4'd0, imm[5] && !kind[0] && !w, imm[4:0]};
        end
        case (kind)
            3'd0: op = rv_int_pkg::op_alri;
            3'd1: op = rv_int_pkg::op_alrr;
            3'd2: op = rv_int_pkg::op_alriw;
            3'd3: op = rv_int_pkg::op_alrrw;
            default: op = rv_int_pkg::op_lui;
        endcase
        return {imm, rs1, f3, rd, op};
    endfunction

    // expected rd and data from the register model; returns legality
    function automatic logic ref_exec(input logic [31:0] ins, output logic [4:0] rd,
                                      output logic [63:0] data);
        logic [6:0]  op;
        logic        rr;
        logic        w;
        logic [63:0] a;
        logic [63:0] b;
        logic [5:0]  sh;
        op = ins[6:0];
        rr = (op == rv_int_pkg::op_alrr) || (op == rv_int_pkg::op_alrrw);
        w  = (op == rv_int_pkg::op_alriw) || (op == rv_int_pkg::op_alrrw);
        rd = ins[11:7];
        a  = model[ins[19:15]];
        b  = rr ? model[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
        if (w) begin
            a = {{32{a[31]}}, a[31:0]};
            b = {{32{b[31]}}, b[31:0]};
        end
        sh = w ? {1'b0, b[4:0]} : b[5:0];
        case (ins[14:12])
            rv_int_pkg::f3_add:  data = (rr && ins[30]) ? a - b : a + b;
            rv_int_pkg::f3_sll:  data = a << sh;
            rv_int_pkg::f3_slt:  data = {63'd0, $signed(a) < $signed(b)};
            rv_int_pkg::f3_sltu: data = {63'd0, a < b};
            rv_int_pkg::f3_xor:  data = a ^ b;
            rv_int_pkg::f3_sr: begin
                if (ins[30]) begin
                    data = $signed(a) >>> sh;
                end else begin
                    data = w ? {32'd0, a[31:0]} >> sh : a >> sh;
                end
            end
            rv_int_pkg::f3_or:   data = a | b;
            default:             data = a & b;
        endcase
        if (op == rv_int_pkg::op_lui) begin
            data = {{32{ins[31]}}, ins[31:12], 12'h000};
        end
        if (w) begin
            data = {{32{data[31]}}, data[31:0]};
        end
        return (op == rv_int_pkg::op_alri) || rr || w || (op == rv_int_pkg::op_lui);
    endfunction

    // one clock, retire ready redrawn when throttled
    task automatic tick();
        if (throttle) begin
            wb_ready_i <= 1'(rand_bits(1));
        end else begin
            wb_ready_i <= 1'b1;
        end
        @(posedge c_clk);
    endtask

    task automatic send(input logic [31:0] ins);
        in_valid_i <= 1'b1;
        in_instr_i <= ins;
        tick();
        while (!in_ready_o) begin
            tick();
        end
    endtask

    task automatic idle(input int n);
        in_valid_i <= 1'b0;
        repeat (n) tick();
    endtask

    task automatic rand_stream(input int count, input logic [2:0] base, input logic [2:0] span,
                               input logic gaps, input logic illegal);
        logic [31:0] ins;
        throttle = gaps;
        for (int i = 0; i < count; i++) begin
            ins = rand_instr(base + 3'(rand_bits(3)) % span);
            if (illegal && 2'(rand_bits(2)) == 2'd0) begin
                ins[6:0] = 7'(rand_bits(7));
            end
            if (gaps && 2'(rand_bits(2)) == 2'd0) begin
                idle(1 + int'(2'(rand_bits(2))));
            end
            send(ins);
        end
    endtask

    task automatic finish_test(input string name);
        in_valid_i <= 1'b0;
        wb_ready_i <= 1'b1;
        throttle = 1'b0;
        @(negedge c_clk);
        while (exp_q.size() != 0) begin
            @(negedge c_clk);
        end
        $display("test %s done: %0d results checked, %0d errors", name,
                 checks - seen_checks, errors - seen_errors);
        seen_checks = checks;
        seen_errors = errors;
        @(posedge c_clk);
    endtask

    always @(posedge c_clk) begin : monitor
        logic [68:0] want;
        logic [4:0]  rd;
        logic [63:0] data;
        if (c_rst_n) begin
            // both stages are full only with two legal entries in flight
            if (in_ready_o !== ((exp_q.size() < 2) || wb_ready_i)) begin
                $display("error at %0t: in_ready_o %b with %0d in flight and wb_ready_i %b",
                         $time, in_ready_o, exp_q.size(), wb_ready_i);
                errors++;
            end
            if (hold && (!wb_valid_o || wb_rd_o !== hold_rd || wb_data_o !== hold_data)) begin
                $display("error at %0t: retire payload changed before its handshake", $time);
                errors++;
            end
            if (wb_valid_o && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("the core retired a result with no instruction outstanding");
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    checks++;
                    if (wb_rd_o !== want[68:64] || wb_data_o !== want[63:0]) begin
                        $display("error at %0t: got rd %0d data %h, expected rd %0d data %h",
                                 $time, wb_rd_o, wb_data_o, want[68:64], want[63:0]);
                        errors++;
                    end
                end
            end
            hold      = wb_valid_o && !wb_ready_i;
            hold_rd   = wb_rd_o;
            hold_data = wb_data_o;
            // queue in program order at acceptance
            if (in_valid_i && in_ready_o && ref_exec(in_instr_i, rd, data)) begin
                exp_q.push_back({rd, data});
                if (rd != 5'd0) begin
                    model[rd] = data;
                end
            end
        end
    end

    initial begin
        logic [4:0]  rd;
        logic [4:0]  prev;
        logic [31:0] ins;
        c_rst_n    <= 1'b0;
        in_valid_i <= 1'b0;
        in_instr_i <= '0;
        wb_ready_i <= 1'b1;
        throttle = 1'b0;
        lfsr = 32'h888ed4b2;
        repeat (16) @(posedge c_clk);
        c_rst_n <= 1'b1;
        tick();

        // x1..x31 loaded from x0 first
        for (int r = 1; r < 32; r++) begin
            send({12'(rand_bits(12)), 5'd0, rv_int_pkg::f3_add, 5'(r), rv_int_pkg::op_alri});
        end
        rand_stream(60, 3'd0, 3'd1, 1'b0, 1'b0);
        finish_test("register-immediate");

        // each op reads the result of the one before
        prev = 5'd1;
        for (int i = 0; i < 60; i++) begin
            ins = rand_instr(3'd1);
            ins[19:15] = prev;
            if (ins[11:7] == 5'd0) begin
                ins[11:7] = 5'd1;
            end
            prev = ins[11:7];
            send(ins);
        end
        finish_test("register-register chain");

        rand_stream(60, 3'd2, 3'd2, 1'b0, 1'b0);
        finish_test("word ops");

        // every fourth pair targets x0, then x0 is read back
        for (int i = 0; i < 20; i++) begin
            rd = (i % 4 == 0) ? 5'd0 : (5'(rand_bits(5)) | 5'd1);
            send({20'(rand_bits(20)), rd, rv_int_pkg::op_lui});
            send({12'(rand_bits(12)), rd, rv_int_pkg::f3_add, rd, rv_int_pkg::op_alri});
            send({7'd0, 5'd0, rd, rv_int_pkg::f3_or, 5'(rand_bits(5)) | 5'd1,
                  rv_int_pkg::op_alrr});
        end
        finish_test("lui constants and x0");

        rand_stream(150, 3'd0, 3'd5, 1'b1, 1'b0);
        finish_test("throttled mix");

        rand_stream(100, 3'd0, 3'd5, 1'b1, 1'b1);
        finish_test("illegal opcodes");

        // a few quiet cycles catch a stray retire after the last test
        idle(2);
        @(negedge c_clk);
        $display("%0d results checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
